/* Bender.yml */
package:
  name: fetch_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_pkg.sv
      - predictor/bht.sv
      - predictor/btb.sv
      - design/inst_mem.sv
      - design/pc_gen.sv
      - design/fetch_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/fetch_tb.sv

/* common/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Branch history table size, indexed by pc[7:2]
`define FETCH_BHT_ENTRIES 64

// Branch target buffer size, direct mapped
`define FETCH_BTB_ENTRIES 16

// Instruction memory depth in 32-bit words
`define FETCH_IMEM_WORDS 256

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

/* common/fetch_pkg.sv */
package fetch_pkg;

    // RV32I major opcodes, only OP_BRANCH is predicted
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Two-bit saturating counter, upper bit set means taken
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_e;

    // Execute stage report on one resolved branch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        mispredict;
    } resolve_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] target;
    } btb_lookup_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_out_t;

    // Program load, addr is a word index
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } imem_load_t;

endpackage

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  resolve_t    resolve,
    input  imem_load_t  load,
    output fetch_out_t  fetch
);

    logic [31:0] pc;
    logic [31:0] inst;
    logic        pred_taken;
    btb_lookup_t lookup;

    pc_gen u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resolve    (resolve),
        .inst       (inst),
        .pred_taken (pred_taken),
        .lookup     (lookup),
        .pc         (pc),
        .fetch      (fetch)
    );

    inst_mem u_inst_mem (
        .clk  (clk),
        .pc   (pc),
        .load (load),
        .inst (inst)
    );

    // Direction predictor
    bht u_bht (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .resolve    (resolve),
        .pred_taken (pred_taken)
    );

    // Target predictor
    btb u_btb (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .resolve (resolve),
        .lookup  (lookup)
    );

endmodule

/* design/inst_mem.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module inst_mem
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic [31:0] pc,
    input  imem_load_t  load,
    output logic [31:0] inst
);

    localparam int ADDR_W = $clog2(`FETCH_IMEM_WORDS);

    logic [31:0]       mem [`FETCH_IMEM_WORDS];
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] wr_addr;

    // Upper address bits are dropped so accesses wrap
    assign rd_addr = pc[ADDR_W+1:2];
    assign wr_addr = load.addr[ADDR_W-1:0];

    // Program load port
    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[wr_addr] <= load.data;
        end
    end

    // Combinational read
    assign inst = mem[rd_addr];

    a_load_in_range: assert property (
        @(posedge clk) load.valid |-> load.addr < `FETCH_IMEM_WORDS
    );

endmodule

/* design/pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  resolve_t    resolve,
    input  logic [31:0] inst,
    input  logic        pred_taken,
    input  btb_lookup_t lookup,
    output logic [31:0] pc,
    output fetch_out_t  fetch
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;
    logic [31:0] pc_plus4;
    logic [31:0] redirect_pc;
    logic        redirect;
    logic        is_branch;
    logic        predict_taken;
    opcode_e     opcode;

    // Predecode
    assign opcode    = opcode_e'(inst[6:0]);
    assign is_branch = (opcode == OP_BRANCH);

    // All three must agree before we leave the sequential path
    assign predict_taken = is_branch && lookup.hit && pred_taken;

    assign pc_plus4    = pc_q + 32'd4;
    assign redirect    = resolve.valid && resolve.mispredict;
    assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc_q;
        end else if (predict_taken) begin
            pc_next = lookup.target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

    // pred_target is the predicted address of the next fetch
    assign fetch.pc          = pc_q;
    assign fetch.inst        = inst;
    assign fetch.pred_taken  = predict_taken;
    assign fetch.pred_target = predict_taken ? lookup.target : pc_plus4;

    // Targets come from execute and the BTB, so alignment is not local
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00
    );

    a_pc_in_range: assert property (
        @(posedge clk) disable iff (rst) pc_q[31:2] < `FETCH_IMEM_WORDS
    );

endmodule

/* predictor/bht.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module bht
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  resolve_t    resolve,
    output logic        pred_taken
);

    localparam int IDX_W = $clog2(`FETCH_BHT_ENTRIES);

    counter_e         counters [`FETCH_BHT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    counter_e         cur_cnt;
    counter_e         nxt_cnt;

    assign rd_idx  = pc[IDX_W+1:2];
    assign wr_idx  = resolve.pc[IDX_W+1:2];
    assign cur_cnt = counters[wr_idx];

    // One step toward the outcome, saturating at both ends
    always_comb begin
        nxt_cnt = cur_cnt;
        case (cur_cnt)
            CNT_STRONG_NT: nxt_cnt = resolve.taken ? CNT_WEAK_NT  : CNT_STRONG_NT;
            CNT_WEAK_NT:   nxt_cnt = resolve.taken ? CNT_WEAK_T   : CNT_STRONG_NT;
            CNT_WEAK_T:    nxt_cnt = resolve.taken ? CNT_STRONG_T : CNT_WEAK_NT;
            CNT_STRONG_T:  nxt_cnt = resolve.taken ? CNT_STRONG_T : CNT_WEAK_T;
            default:       nxt_cnt = CNT_WEAK_NT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FETCH_BHT_ENTRIES; i++) begin
                counters[i] <= CNT_WEAK_NT;
            end
        end else if (resolve.valid) begin
            counters[wr_idx] <= nxt_cnt;
        end
    end

    assign pred_taken = (counters[rd_idx] == CNT_WEAK_T) ||
                        (counters[rd_idx] == CNT_STRONG_T);

    // Catches X or corrupted state anywhere in the table
    for (genvar i = 0; i < `FETCH_BHT_ENTRIES; i++) begin : g_cnt_chk
        a_cnt_legal: assert property (
            @(posedge clk) disable iff (rst)
            counters[i] inside {CNT_STRONG_NT, CNT_WEAK_NT, CNT_WEAK_T, CNT_STRONG_T}
        );
    end

endmodule

/* predictor/btb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module btb
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  resolve_t    resolve,
    output btb_lookup_t lookup
);

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    logic [TAG_W-1:0]             tag_q    [`FETCH_BTB_ENTRIES];
    logic [31:0]                  target_q [`FETCH_BTB_ENTRIES];
    logic [`FETCH_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_match;

    // Word index from low bits, tag from everything above
    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[31:IDX_W+2];
    assign wr_idx = resolve.pc[IDX_W+1:2];
    assign wr_tag = resolve.pc[31:IDX_W+2];

    assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (resolve.valid) begin
            if (resolve.taken) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (wr_match) begin
                // Only drop the entry that belongs to this branch
                valid_q[wr_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid && resolve.taken) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= resolve.target;
        end
    end

    assign lookup.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign lookup.target = target_q[rd_idx];

endmodule

/* project.f */
+incdir+common
common/fetch_pkg.sv
predictor/bht.sv
predictor/btb.sv
design/inst_mem.sv
design/pc_gen.sv
design/fetch_stage.sv
testbench/fetch_tb.sv

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();

    // Program load takes 256 cycles and the directed tests a few hundred more
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] B1_PC  = 32'h100;
    localparam logic [31:0] B1_TGT = 32'h300;
    // Same BTB index as B1 but a different tag
    localparam logic [31:0] B2_PC  = 32'h140;
    localparam logic [31:0] B2_TGT = 32'h340;
    localparam logic [31:0] NB_PC  = 32'h184;
    // Shares the BHT counter of B1 but not its BTB tag
    localparam logic [31:0] ALIAS_PC = 32'h200;

    logic       clk;
    logic       rst;
    logic       stall;
    resolve_t   resolve;
    imem_load_t load;
    fetch_out_t fetch;
    int         cycles = 0;
    logic [15:0] lfsr;

    // Reference model state
    logic [31:0] pc_m;
    logic [31:0] mem_m [`FETCH_IMEM_WORDS];
    counter_e    cnt_m [`FETCH_BHT_ENTRIES];
    logic        btb_valid_m [`FETCH_BTB_ENTRIES];
    logic [31:0] btb_tag_m [`FETCH_BTB_ENTRIES];
    logic [31:0] btb_target_m [`FETCH_BTB_ENTRIES];

    fetch_stage UUT (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .resolve (resolve),
        .load    (load),
        .fetch   (fetch)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic filler_word(output logic [31:0] word);
        int i;
        word = '0;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[30:0], lfsr[0]};
        end
        // Never a branch
        if (word[6:0] == OP_BRANCH) begin
            word[2] = ~word[2];
        end
    endtask

    // beq x1, x2, offset
    task automatic make_branch(input logic [12:0] off, output logic [31:0] word);
        word = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OP_BRANCH};
    endtask

    task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got pc=%h inst=%h pt=%b tgt=%h", $time, what,
                     got.pc, got.inst, got.pred_taken, got.pred_target);
            $display("  expected pc=%h inst=%h pt=%b tgt=%h",
                     exp.pc, exp.inst, exp.pred_taken, exp.pred_target);
            $display("Testbench failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    function automatic fetch_out_t expected_fetch();
        fetch_out_t  e;
        int          bi;
        int          bj;
        logic        hit;
        logic        ctr_taken;
        bi = (pc_m >> 2) % `FETCH_BHT_ENTRIES;
        bj = (pc_m >> 2) % `FETCH_BTB_ENTRIES;
        hit = btb_valid_m[bj] && (btb_tag_m[bj] == (pc_m >> 2) / `FETCH_BTB_ENTRIES);
        ctr_taken = (cnt_m[bi] == CNT_WEAK_T) || (cnt_m[bi] == CNT_STRONG_T);
        e.pc = pc_m;
        e.inst = mem_m[(pc_m >> 2) % `FETCH_IMEM_WORDS];
        e.pred_taken = (e.inst[6:0] == OP_BRANCH) && hit && ctr_taken;
        e.pred_target = e.pred_taken ? btb_target_m[bj] : pc_m + 32'd4;
        return e;
    endfunction

    task automatic update_tables(input resolve_t r);
        int          bi;
        int          bj;
        logic [1:0]  c;
        logic [31:0] tag;
        bi = (r.pc >> 2) % `FETCH_BHT_ENTRIES;
        bj = (r.pc >> 2) % `FETCH_BTB_ENTRIES;
        tag = (r.pc >> 2) / `FETCH_BTB_ENTRIES;
        c = cnt_m[bi];
        if (r.taken && c != 2'b11) begin
            c = c + 2'd1;
        end else if (!r.taken && c != 2'b00) begin
            c = c - 2'd1;
        end
        cnt_m[bi] = counter_e'(c);
        if (r.taken) begin
            btb_valid_m[bj] = 1'b1;
            btb_tag_m[bj] = tag;
            btb_target_m[bj] = r.target;
        end else if (btb_valid_m[bj] && btb_tag_m[bj] == tag) begin
            btb_valid_m[bj] = 1'b0;
        end
    endtask

    // Check outputs for one clock, advance the model and clear strobes
    task automatic tick();
        fetch_out_t  exp;
        logic [31:0] nxt;
        exp = expected_fetch();
        check_fetch(fetch, exp, "fetch output");
        if (resolve.valid && resolve.mispredict) begin
            nxt = resolve.taken ? resolve.target : resolve.pc + 32'd4;
        end else if (stall) begin
            nxt = pc_m;
        end else begin
            nxt = exp.pred_target;
        end
        if (resolve.valid) begin
            update_tables(resolve);
        end
        pc_m = nxt;
        @(negedge clk);
        resolve = '0;
    endtask

    task automatic send_resolve(input logic [31:0] pc, input logic taken,
                                input logic [31:0] target, input logic mispredict);
        resolve.valid = 1'b1;
        resolve.pc = pc;
        resolve.taken = taken;
        resolve.target = target;
        resolve.mispredict = mispredict;
        tick();
    endtask

    task automatic jump_to(input logic [31:0] addr);
        send_resolve(addr - 32'd4, 1'b0, 32'd0, 1'b1);
    endtask

    // Fetch one word and check the prediction and the PC that follows
    task automatic visit_pc(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        fetch_out_t exp;
        jump_to(pc);
        exp.pc = pc;
        exp.inst = mem_m[(pc >> 2) % `FETCH_IMEM_WORDS];
        exp.pred_taken = taken;
        exp.pred_target = taken ? target : pc + 32'd4;
        check_fetch(fetch, exp, "visited fetch");
        tick();
        check_pc(fetch.pc, exp.pred_target, "pc after visit");
    endtask

    task automatic load_program();
        logic [31:0] word;
        int          i;
        stall = 1'b1;
        for (i = 0; i < `FETCH_IMEM_WORDS; i++) begin
            if (i == B1_PC / 4) begin
                make_branch(13'(B1_TGT - B1_PC), word);
            end else if (i == B2_PC / 4) begin
                make_branch(13'(B2_TGT - B2_PC), word);
            end else begin
                filler_word(word);
            end
            mem_m[i] = word;
            load.valid = 1'b1;
            load.addr = i;
            load.data = word;
            @(negedge clk);
        end
        load = '0;
        stall = 1'b0;
    endtask

    task automatic test_sequential();
        repeat (20) tick();
        check_pc(fetch.pc, `FETCH_RESET_PC + 32'd80, "sequential pc");
    endtask

    task automatic test_stall();
        fetch_out_t held;
        stall = 1'b1;
        held = expected_fetch();
        repeat (4) begin
            tick();
            check_fetch(fetch, held, "stalled fetch");
        end
        send_resolve(32'h20, 1'b1, 32'h60, 1'b1);
        check_pc(fetch.pc, 32'h60, "taken redirect under stall");
        send_resolve(32'h88, 1'b0, 32'h0, 1'b1);
        check_pc(fetch.pc, 32'h8c, "not-taken redirect under stall");
        stall = 1'b0;
    endtask

    task automatic test_first_taken();
        visit_pc(B1_PC, 1'b0, B1_TGT);
        send_resolve(B1_PC, 1'b1, B1_TGT, 1'b1);
        check_pc(fetch.pc, B1_TGT, "branch redirect");
        visit_pc(B1_PC, 1'b1, B1_TGT);
    endtask

    task automatic test_saturate();
        repeat (3) send_resolve(B1_PC, 1'b1, B1_TGT, 1'b0);
        visit_pc(B1_PC, 1'b1, B1_TGT);
        // Matching tag drops the entry
        send_resolve(B1_PC, 1'b0, 32'h0, 1'b0);
        visit_pc(B1_PC, 1'b0, B1_TGT);
        send_resolve(B1_PC, 1'b1, B1_TGT, 1'b0);
        visit_pc(B1_PC, 1'b1, B1_TGT);
        // Lowers the shared counter and leaves the BTB entry of B1 valid
        send_resolve(ALIAS_PC, 1'b0, 32'h0, 1'b0);
        visit_pc(B1_PC, 1'b1, B1_TGT);
        send_resolve(ALIAS_PC, 1'b0, 32'h0, 1'b0);
        visit_pc(B1_PC, 1'b0, B1_TGT);
        send_resolve(B1_PC, 1'b1, B1_TGT, 1'b0);
        visit_pc(B1_PC, 1'b1, B1_TGT);
    endtask

    task automatic test_non_branch();
        repeat (2) send_resolve(NB_PC, 1'b1, B1_TGT, 1'b0);
        visit_pc(NB_PC, 1'b0, B1_TGT);
    endtask

    task automatic test_alias();
        send_resolve(B2_PC, 1'b1, B2_TGT, 1'b0);
        send_resolve(B1_PC, 1'b1, B1_TGT, 1'b0);
        visit_pc(B2_PC, 1'b0, B2_TGT);
        visit_pc(B1_PC, 1'b1, B1_TGT);
        send_resolve(B2_PC, 1'b1, B2_TGT, 1'b0);
        visit_pc(B1_PC, 1'b0, B1_TGT);
        visit_pc(B2_PC, 1'b1, B2_TGT);
    endtask

    initial begin
        int i;
        rst = 1'b1;
        stall = 1'b0;
        resolve = '0;
        load = '0;
        lfsr = 16'd41;
        pc_m = `FETCH_RESET_PC;
        for (i = 0; i < `FETCH_BHT_ENTRIES; i++) begin
            cnt_m[i] = CNT_WEAK_NT;
        end
        for (i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
            btb_valid_m[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        load_program();
        test_sequential();
        test_stall();
        test_first_taken();
        test_saturate();
        test_non_branch();
        test_alias();
        $display("Testbench passed");
        $finish;
    end

endmodule
